// ==== logic/nice_cfg.svh ====
/* build-time constants of the NICE coprocessor core
   include wherever a width, row length or instruction code is needed */
`ifndef NICE_CFG_SVH
`define NICE_CFG_SVH

`define NICE_XLEN        32
`define NICE_ROW_LEN     3
`define NICE_IDX_W       2
`define NICE_ADDR_STEP   4

`define NICE_OPC_CUSTOM3 7'b1111011

`define NICE_F3_ADD      3'b111
`define NICE_F3_LBUF     3'b010
`define NICE_F3_SBUF     3'b010
`define NICE_F3_ROWSUM   3'b110
`define NICE_F3_CROWBUF  3'b000

`define NICE_F7_ADD      7'b0000000
`define NICE_F7_LBUF     7'b0000001
`define NICE_F7_SBUF     7'b0000010
`define NICE_F7_ROWSUM   7'b0000110
`define NICE_F7_CROWBUF  7'b0000111

`endif

// ==== logic/nice_isa_pkg.sv ====
/* instruction-side types of the NICE core
   used by the decoder, the sequencer and the testbench stimulus */
`include "nice_cfg.svh"

package nice_isa_pkg;

   typedef logic [`NICE_XLEN-1:0] word_t;   // register or data word
   typedef logic [31:0]           inst_t;

   // operation selected by the decoder
   typedef enum logic [2:0] {
      OP_ADD     = 3'd0,
      OP_LBUF    = 3'd1,
      OP_SBUF    = 3'd2,
      OP_ROWSUM  = 3'd3,
      OP_CROWBUF = 3'd4,
      OP_ILLEGAL = 3'd7
   } nice_op_e;

   typedef struct packed {
      nice_op_e op;
      logic     multi;   // answers on the response port
      logic     mem;     // needs memory commands
      word_t    rs1;
      word_t    rs2;
   } req_dec_t;

endpackage

// ==== logic/nice_icb_pkg.sv ====
/* memory bus and internal datapath types of the NICE core
   compile after nice_isa_pkg */
`include "nice_cfg.svh"

package nice_icb_pkg;

   typedef logic [31:0]            addr_t;
   typedef logic [`NICE_IDX_W-1:0] row_idx_t;

   typedef struct packed {
      logic                valid;
      addr_t               addr;
      logic                read;    // low for a store
      nice_isa_pkg::word_t wdata;
   } icb_cmd_t;

   typedef struct packed {
      logic                valid;
      nice_isa_pkg::word_t rdata;
      logic                err;
   } icb_rsp_t;

   // multi-cycle answer to the host
   typedef struct packed {
      logic                valid;
      nice_isa_pkg::word_t rdat;
      logic                err;
   } rsp_t;

   typedef struct packed {
      logic                valid;
      row_idx_t            idx;
      nice_isa_pkg::word_t data;
   } rowbuf_wr_t;

   typedef struct packed {
      logic                valid;
      row_idx_t            idx;
      nice_isa_pkg::word_t data;
   } rowsum_cap_t;

   typedef struct packed {
      logic                valid;
      row_idx_t            idx;
      nice_isa_pkg::word_t data;   // added to the entry
   } rowsum_upd_t;

endpackage

// ==== logic/nice_req_decode.sv ====
/* custom-3 instruction decoder
   classifies the request and answers add, crowbuf and illegal ops in zero cycles */
`include "nice_cfg.svh"

module nice_req_decode (
   input  logic                   i_req_valid,
   input  nice_isa_pkg::inst_t    i_req_inst,
   input  nice_isa_pkg::word_t    i_req_rs1,
   input  nice_isa_pkg::word_t    i_req_rs2,
   input  logic                   i_req_hsk,
   output nice_isa_pkg::req_dec_t o_dec,
   output logic                   o_1cyc_type,
   output nice_isa_pkg::word_t    o_1cyc_rdat,
   output logic                   o_1cyc_err,
   output logic                   o_rowbuf_clr
);

   logic [6:0]             opcode;
   logic [2:0]             func3;
   logic [6:0]             func7;
   nice_isa_pkg::nice_op_e op;
   logic                   is_row_op;
   logic                   is_1cyc;

   assign opcode = i_req_inst[6:0];
   assign func3  = i_req_inst[14:12];
   assign func7  = i_req_inst[31:25];

   always_comb begin
      op = nice_isa_pkg::OP_ILLEGAL;
      if (opcode == `NICE_OPC_CUSTOM3) begin
         case ({func3, func7})
            {`NICE_F3_ADD, `NICE_F7_ADD}:         op = nice_isa_pkg::OP_ADD;
            {`NICE_F3_LBUF, `NICE_F7_LBUF}:       op = nice_isa_pkg::OP_LBUF;
            {`NICE_F3_SBUF, `NICE_F7_SBUF}:       op = nice_isa_pkg::OP_SBUF;
            {`NICE_F3_ROWSUM, `NICE_F7_ROWSUM}:   op = nice_isa_pkg::OP_ROWSUM;
            {`NICE_F3_CROWBUF, `NICE_F7_CROWBUF}: op = nice_isa_pkg::OP_CROWBUF;
            default:                              op = nice_isa_pkg::OP_ILLEGAL;
         endcase
      end
   end

   // every row op goes through memory
   assign is_row_op = (op == nice_isa_pkg::OP_LBUF) || (op == nice_isa_pkg::OP_SBUF) ||
                      (op == nice_isa_pkg::OP_ROWSUM);
   assign is_1cyc   = !is_row_op;   // add, crowbuf and illegal

   assign o_dec = '{op:    op,
                    multi: i_req_valid && is_row_op,
                    mem:   i_req_valid && is_row_op,
                    rs1:   i_req_rs1,
                    rs2:   i_req_rs2};

   assign o_1cyc_type  = i_req_hsk && is_1cyc;
   assign o_1cyc_err   = i_req_hsk && (op == nice_isa_pkg::OP_ILLEGAL);
   assign o_rowbuf_clr = i_req_hsk && (op == nice_isa_pkg::OP_CROWBUF);
   assign o_1cyc_rdat  = (op == nice_isa_pkg::OP_ADD) ? i_req_rs1 + i_req_rs2 : '0;

endmodule

// ==== logic/nice_mem_seq.sv ====
/* memory sequencer for the lbuf, sbuf and rowsum row operations
   issues three commands ahead of their responses and holds the core response until taken */
`include "nice_cfg.svh"

module nice_mem_seq (
   input  logic                        nice_clk,
   input  logic                        i_arst_n,
   input  nice_isa_pkg::req_dec_t      i_dec,
   input  logic                        i_req_valid,
   output logic                        o_req_ready,
   output logic                        o_req_hsk,
   output nice_icb_pkg::icb_cmd_t      o_icb_cmd,
   input  logic                        i_icb_cmd_ready,
   input  nice_icb_pkg::icb_rsp_t      i_icb_rsp,
   input  nice_isa_pkg::word_t         i_store_word,
   output nice_icb_pkg::row_idx_t      o_store_idx,
   output nice_icb_pkg::rowbuf_wr_t    o_rowbuf_wr,
   input  nice_isa_pkg::word_t         i_sum,
   input  logic                        i_sum_done,
   output nice_icb_pkg::rowsum_cap_t   o_cap,
   output nice_icb_pkg::rsp_t          o_rsp,
   input  logic                        i_rsp_ready
);

   typedef enum logic [2:0] {IDLE, LBUF, SBUF, ROWSUM, RESP} seq_state_e;

   localparam nice_icb_pkg::row_idx_t LAST_IDX = nice_icb_pkg::row_idx_t'(`NICE_ROW_LEN - 1);

   seq_state_e             state;
   seq_state_e             state_nxt;
   nice_icb_pkg::row_idx_t cmd_cnt;    // commands taken in this op
   nice_icb_pkg::row_idx_t rsp_cnt;
   nice_icb_pkg::addr_t    addr_acc;   // address of the next command
   logic                   busy;
   logic                   cmd_hsk;
   logic                   rsp_in;
   logic                   rsp_last;
   logic                   rsp_hsk;
   logic                   enter_resp;
   logic                   err_acc;
   logic                   err_nxt;
   nice_isa_pkg::word_t    rsp_rdat;
   logic                   rsp_err;

   assign busy        = (state == LBUF) || (state == SBUF) || (state == ROWSUM);
   // first command leaves together with the request
   assign o_req_ready = (state == IDLE) && (!i_dec.mem || i_icb_cmd_ready);
   assign o_req_hsk   = i_req_valid && o_req_ready;

   assign o_icb_cmd = '{valid: ((state == IDLE) && i_dec.mem) ||
                               (busy && (cmd_cnt < `NICE_ROW_LEN)),
                        addr:  (state == IDLE) ? i_dec.rs1 : addr_acc,
                        read:  (state == IDLE) ? (i_dec.op != nice_isa_pkg::OP_SBUF)
                                               : (state != SBUF),
                        wdata: i_store_word};
   assign o_store_idx = cmd_cnt;   // zero while idle
   assign cmd_hsk     = o_icb_cmd.valid && i_icb_cmd_ready;

   assign rsp_in   = i_icb_rsp.valid && busy;
   assign rsp_last = rsp_in && (rsp_cnt == LAST_IDX);
   assign err_nxt  = err_acc || (rsp_in && i_icb_rsp.err);

   assign o_rowbuf_wr = '{valid: rsp_in && (state == LBUF), idx: rsp_cnt,
                          data: i_icb_rsp.rdata};
   assign o_cap       = '{valid: rsp_in && (state == ROWSUM), idx: rsp_cnt,
                          data: i_icb_rsp.rdata};

   assign o_rsp      = '{valid: state == RESP, rdat: rsp_rdat, err: rsp_err};
   assign rsp_hsk    = o_rsp.valid && i_rsp_ready;
   assign enter_resp = busy && (state_nxt == RESP);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (o_req_hsk && i_dec.multi) begin
               case (i_dec.op)
                  nice_isa_pkg::OP_LBUF: state_nxt = LBUF;
                  nice_isa_pkg::OP_SBUF: state_nxt = SBUF;
                  default:               state_nxt = ROWSUM;
               endcase
            end
         end
         LBUF, SBUF: begin
            if (rsp_last) state_nxt = RESP;
         end
         ROWSUM: begin
            if (i_sum_done) state_nxt = RESP;   // accumulator lags the last response
         end
         default: begin
            if (rsp_hsk) state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge nice_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= IDLE;
         cmd_cnt <= '0;
         rsp_cnt <= '0;
         err_acc <= 1'b0;
      end else begin
         state <= state_nxt;
         if (o_req_hsk) begin
            cmd_cnt <= nice_icb_pkg::row_idx_t'(i_dec.mem);
            rsp_cnt <= '0;
            err_acc <= 1'b0;
         end else begin
            if (busy && cmd_hsk) cmd_cnt <= cmd_cnt + 1'b1;
            else if (state == RESP) cmd_cnt <= '0;
            if (rsp_in) begin
               rsp_cnt <= rsp_cnt + 1'b1;
               err_acc <= err_nxt;
            end
         end
      end
   end

   always_ff @(posedge nice_clk) begin
      if (o_req_hsk) addr_acc <= i_dec.rs1 + nice_icb_pkg::addr_t'(`NICE_ADDR_STEP);
      else if (busy && cmd_hsk) addr_acc <= addr_acc + nice_icb_pkg::addr_t'(`NICE_ADDR_STEP);
      if (enter_resp) begin
         rsp_rdat <= (state == ROWSUM) ? i_sum : '0;
         rsp_err  <= err_nxt;
      end
   end

   a_idle_cmd: assert property (@(posedge nice_clk) disable iff (!i_arst_n)
      (state == IDLE && o_icb_cmd.valid) |->
         (i_req_valid && (i_dec.op inside {nice_isa_pkg::OP_LBUF, nice_isa_pkg::OP_SBUF,
                                           nice_isa_pkg::OP_ROWSUM})));

   // after the last command of an op nothing more goes out until idle
   a_cmd_limit: assert property (@(posedge nice_clk) disable iff (!i_arst_n)
      (busy && cmd_hsk && cmd_cnt == LAST_IDX) |=> (!o_icb_cmd.valid until (state == IDLE)));

endmodule

// ==== logic/nice_rowsum_acc.sv ====
/* rowsum accumulator
   buffers each read word, sums the row and forwards the word as a row-buffer update */
`include "nice_cfg.svh"

module nice_rowsum_acc (
   input  logic                      nice_clk,
   input  logic                      i_arst_n,
   input  nice_icb_pkg::rowsum_cap_t i_cap,
   output nice_icb_pkg::rowsum_upd_t o_upd,
   output nice_isa_pkg::word_t       o_sum,
   output logic                      o_sum_done
);

   localparam nice_icb_pkg::row_idx_t LAST_IDX = nice_icb_pkg::row_idx_t'(`NICE_ROW_LEN - 1);

   logic                   buf_vld;
   nice_icb_pkg::row_idx_t buf_idx;
   nice_isa_pkg::word_t    buf_data;   // received word
   nice_isa_pkg::word_t    acc_q;
   logic                   done_q;

   always_ff @(posedge nice_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         buf_vld <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         buf_vld <= i_cap.valid;
         done_q  <= buf_vld && (buf_idx == LAST_IDX);   // sum final on the same edge
      end
   end

   always_ff @(posedge nice_clk) begin
      if (i_cap.valid) begin
         buf_idx  <= i_cap.idx;
         buf_data <= i_cap.data;
      end
      // first word of a row restarts the sum
      if (buf_vld) begin
         acc_q <= (buf_idx == '0) ? buf_data : acc_q + buf_data;
      end
   end

   assign o_upd      = '{valid: buf_vld, idx: buf_idx, data: buf_data};
   assign o_sum      = acc_q;
   assign o_sum_done = done_q;

   a_cap_idx: assert property (@(posedge nice_clk) disable iff (!i_arst_n)
      i_cap.valid |-> (i_cap.idx < `NICE_ROW_LEN));

endmodule

// ==== logic/nice_row_buffer.sv ====
/* row buffer of NICE_ROW_LEN words
   loaded by lbuf, added to by rowsum, cleared by crowbuf, read by sbuf */
`include "nice_cfg.svh"

module nice_row_buffer (
   input  logic                      nice_clk,
   input  logic                      i_arst_n,
   input  nice_icb_pkg::rowbuf_wr_t  i_wr,
   input  nice_icb_pkg::rowsum_upd_t i_upd,
   input  logic                      i_clr,
   input  nice_icb_pkg::row_idx_t    i_rd_idx,
   output nice_isa_pkg::word_t       o_rd_word
);

   nice_isa_pkg::word_t rows [`NICE_ROW_LEN];

   always_ff @(posedge nice_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `NICE_ROW_LEN; i++) begin
            rows[i] <= '0;
         end
      end else if (i_clr) begin
         for (int i = 0; i < `NICE_ROW_LEN; i++) begin
            rows[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `NICE_ROW_LEN; i++) begin
            if (i_wr.valid && (i_wr.idx == i)) begin
               rows[i] <= i_wr.data;
            end else if (i_upd.valid && (i_upd.idx == i)) begin
               rows[i] <= rows[i] + i_upd.data;   // rowsum keeps the row plus the read word
            end
         end
      end
   end

   // index runs one past the row once the last store command is out
   assign o_rd_word = (i_rd_idx < `NICE_ROW_LEN) ? rows[i_rd_idx] : '0;

   // lbuf and rowsum never overlap in time
   a_wr_upd_excl: assert property (@(posedge nice_clk) disable iff (!i_arst_n)
      !(i_wr.valid && i_upd.valid));

endmodule

// ==== logic/nice_core.sv ====
/* NICE coprocessor top level
   connect the request, single-cycle result, memory and response ports to the host */

module nice_core (
   input  logic                   nice_clk,
   input  logic                   i_arst_n,
   input  logic                   i_req_valid,
   output logic                   o_req_ready,
   input  nice_isa_pkg::inst_t    i_req_inst,
   input  nice_isa_pkg::word_t    i_req_rs1,
   input  nice_isa_pkg::word_t    i_req_rs2,
   output logic                   o_1cyc_type,
   output nice_isa_pkg::word_t    o_1cyc_rdat,
   output logic                   o_1cyc_err,
   output nice_icb_pkg::icb_cmd_t o_icb_cmd,
   input  logic                   i_icb_cmd_ready,
   input  nice_icb_pkg::icb_rsp_t i_icb_rsp,
   output nice_icb_pkg::rsp_t     o_rsp,
   input  logic                   i_rsp_ready
);

   nice_isa_pkg::req_dec_t    dec;
   logic                      req_hsk;
   logic                      rowbuf_clr;
   nice_isa_pkg::word_t       store_word;
   nice_icb_pkg::row_idx_t    store_idx;
   nice_icb_pkg::rowbuf_wr_t  rowbuf_wr;
   nice_icb_pkg::rowsum_cap_t cap;
   nice_icb_pkg::rowsum_upd_t upd;
   nice_isa_pkg::word_t       sum;
   logic                      sum_done;

   nice_req_decode u_req_decode (
      .i_req_valid  (i_req_valid),
      .i_req_inst   (i_req_inst),
      .i_req_rs1    (i_req_rs1),
      .i_req_rs2    (i_req_rs2),
      .i_req_hsk    (req_hsk),
      .o_dec        (dec),
      .o_1cyc_type  (o_1cyc_type),
      .o_1cyc_rdat  (o_1cyc_rdat),
      .o_1cyc_err   (o_1cyc_err),
      .o_rowbuf_clr (rowbuf_clr)
   );

   nice_mem_seq u_mem_seq (
      .nice_clk        (nice_clk),
      .i_arst_n        (i_arst_n),
      .i_dec           (dec),
      .i_req_valid     (i_req_valid),
      .o_req_ready     (o_req_ready),
      .o_req_hsk       (req_hsk),
      .o_icb_cmd       (o_icb_cmd),
      .i_icb_cmd_ready (i_icb_cmd_ready),
      .i_icb_rsp       (i_icb_rsp),
      .i_store_word    (store_word),
      .o_store_idx     (store_idx),
      .o_rowbuf_wr     (rowbuf_wr),
      .i_sum           (sum),
      .i_sum_done      (sum_done),
      .o_cap           (cap),
      .o_rsp           (o_rsp),
      .i_rsp_ready     (i_rsp_ready)
   );

   nice_rowsum_acc u_rowsum_acc (
      .nice_clk   (nice_clk),
      .i_arst_n   (i_arst_n),
      .i_cap      (cap),
      .o_upd      (upd),
      .o_sum      (sum),
      .o_sum_done (sum_done)
   );

   nice_row_buffer u_row_buffer (
      .nice_clk  (nice_clk),
      .i_arst_n  (i_arst_n),
      .i_wr      (rowbuf_wr),
      .i_upd     (upd),
      .i_clr     (rowbuf_clr),
      .i_rd_idx  (store_idx),
      .o_rd_word (store_word)
   );

endmodule

// ==== verif/nice_mem_model.sv ====
/* in-order memory responder for the NICE core testbench
   random command ready, 1 to 4 cycles of response latency, err raised on one address */

module nice_mem_model (
   input  logic                   nice_clk,
   input  logic                   i_arst_n,
   input  nice_icb_pkg::icb_cmd_t i_cmd,
   input  nice_icb_pkg::addr_t    i_err_addr,
   output logic                   o_cmd_ready,
   output nice_icb_pkg::icb_rsp_t o_rsp
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MEM_WORDS = 256;   // byte addresses 0x000 to 0x3ff

   nice_isa_pkg::word_t mem [MEM_WORDS];
   nice_isa_pkg::word_t rdata_q [$];
   logic                err_q [$];
   int                  due_q [$];   // cycle in which each response goes out
   int unsigned         lcg_state;
   int unsigned         hi;
   int unsigned         lo;
   int                  cyc;
   int                  last_due;
   int                  due;
   int                  widx;

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   initial begin
      lcg_state   = 2;
      cyc         = 0;
      last_due    = 0;
      o_cmd_ready = 1'b0;
      o_rsp       = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         hi     = next_rand();
         lo     = next_rand();
         mem[i] = {hi[15:0], lo[15:0]} ^ (i << 2);   // mixed with the byte address
      end
   end

   // command accepted on the rising edge, response queued in order
   always @(posedge nice_clk) begin
      if (i_arst_n && i_cmd.valid && o_cmd_ready) begin
         widx = int'(i_cmd.addr[9:2]);
         if (!i_cmd.read) mem[widx] = i_cmd.wdata;
         due = cyc + 1 + int'(next_rand() % 4);
         if (due <= last_due) due = last_due + 1;   // keeps responses in order
         last_due = due;
         rdata_q.push_back(i_cmd.read ? mem[widx] : '0);
         err_q.push_back(i_cmd.addr == i_err_addr);
         due_q.push_back(due);
      end
      cyc++;
   end

   always @(negedge nice_clk) begin
      if (!i_arst_n) begin
         o_cmd_ready = 1'b0;
         o_rsp       = '0;
      end else begin
         o_cmd_ready = (next_rand() % 4) != 0;   // ready three cycles in four
         if (due_q.size() > 0 && due_q[0] <= cyc) begin
            o_rsp.valid = 1'b1;
            o_rsp.rdata = rdata_q.pop_front();
            o_rsp.err   = err_q.pop_front();
            void'(due_q.pop_front());
         end else begin
            o_rsp = '0;
         end
      end
   end

endmodule

// ==== verif/nice_core_tb.sv ====
/* testbench of the NICE coprocessor core
   applies a table of instructions and checks results against a shadow row buffer and memory */
`include "nice_cfg.svh"

module nice_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 8;
   localparam int N_TESTS    = 13;
   localparam int WAIT_LIMIT = 50;    // cycles allowed for a handshake or a response
   localparam int MEM_WORDS  = 256;
   localparam nice_icb_pkg::addr_t ERR_ADDR = 32'h0000_0304;

   // func7, rs2, rs1, func3, rd, opcode
   localparam nice_isa_pkg::inst_t INST_ADD =
      {`NICE_F7_ADD, 10'd0, `NICE_F3_ADD, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_LBUF =
      {`NICE_F7_LBUF, 10'd0, `NICE_F3_LBUF, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_SBUF =
      {`NICE_F7_SBUF, 10'd0, `NICE_F3_SBUF, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_ROWSUM =
      {`NICE_F7_ROWSUM, 10'd0, `NICE_F3_ROWSUM, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_CROWBUF =
      {`NICE_F7_CROWBUF, 10'd0, `NICE_F3_CROWBUF, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_BAD_F7 =
      {7'b1111111, 10'd0, `NICE_F3_ADD, 5'd0, `NICE_OPC_CUSTOM3};
   localparam nice_isa_pkg::inst_t INST_BAD_OPC =
      {`NICE_F7_ADD, 10'd0, `NICE_F3_ADD, 5'd0, 7'b0001011};   // custom-0

   typedef struct {
      string                  name;
      nice_isa_pkg::nice_op_e op;
      nice_isa_pkg::inst_t    inst;
      nice_isa_pkg::word_t    rs1;
      nice_isa_pkg::word_t    rs2;
      int                     stall;   // cycles with i_rsp_ready held low
   } test_row_t;

   logic                   nice_clk;
   logic                   i_arst_n;
   logic                   i_req_valid;
   logic                   o_req_ready;
   nice_isa_pkg::inst_t    i_req_inst;
   nice_isa_pkg::word_t    i_req_rs1;
   nice_isa_pkg::word_t    i_req_rs2;
   logic                   o_1cyc_type;
   nice_isa_pkg::word_t    o_1cyc_rdat;
   logic                   o_1cyc_err;
   nice_icb_pkg::icb_cmd_t o_icb_cmd;
   logic                   i_icb_cmd_ready;
   nice_icb_pkg::icb_rsp_t i_icb_rsp;
   nice_icb_pkg::rsp_t     o_rsp;
   logic                   i_rsp_ready;

   test_row_t              tests [N_TESTS];
   nice_isa_pkg::word_t    sh_mem [MEM_WORDS];
   nice_isa_pkg::word_t    sh_row [`NICE_ROW_LEN];
   nice_icb_pkg::icb_cmd_t cmd_q [$];
   logic                   cmd_allowed;   // high while a row operation runs

   nice_core u_nice_core (
      .nice_clk        (nice_clk),
      .i_arst_n        (i_arst_n),
      .i_req_valid     (i_req_valid),
      .o_req_ready     (o_req_ready),
      .i_req_inst      (i_req_inst),
      .i_req_rs1       (i_req_rs1),
      .i_req_rs2       (i_req_rs2),
      .o_1cyc_type     (o_1cyc_type),
      .o_1cyc_rdat     (o_1cyc_rdat),
      .o_1cyc_err      (o_1cyc_err),
      .o_icb_cmd       (o_icb_cmd),
      .i_icb_cmd_ready (i_icb_cmd_ready),
      .i_icb_rsp       (i_icb_rsp),
      .o_rsp           (o_rsp),
      .i_rsp_ready     (i_rsp_ready)
   );

   nice_mem_model u_mem_model (
      .nice_clk    (nice_clk),
      .i_arst_n    (i_arst_n),
      .i_cmd       (o_icb_cmd),
      .i_err_addr  (ERR_ADDR),
      .o_cmd_ready (i_icb_cmd_ready),
      .o_rsp       (i_icb_rsp)
   );

   initial nice_clk = 1'b0;
   always #(CLK_PERIOD / 2) nice_clk = ~nice_clk;

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input nice_isa_pkg::word_t exp,
                             input nice_isa_pkg::word_t act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input nice_icb_pkg::addr_t exp,
                             input nice_icb_pkg::addr_t act);
      if (act !== exp) begin
         $display("Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error %s: expected err %b, actual err %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Error %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   function automatic int word_idx(input nice_icb_pkg::addr_t a);
      return int'(a[9:2]);
   endfunction

   // returns on the rising edge where request ready or response valid is seen
   task automatic wait_for(input string name, input bit want_rsp);
      int n;
      n = 0;
      do begin
         @(posedge nice_clk);
         n++;
         if (n > WAIT_LIMIT) begin
            $display("%s: %s never came", name, want_rsp ? "the response" : "request ready");
            abort_run();
         end
      end while (want_rsp ? !o_rsp.valid : !o_req_ready);
   endtask

   task automatic run_test(input test_row_t t);
      logic                row_op;
      logic                exp_err;
      nice_icb_pkg::addr_t a;
      nice_isa_pkg::word_t w;
      nice_isa_pkg::word_t exp_rdat;
      nice_icb_pkg::rsp_t  held;
      row_op = t.op inside {nice_isa_pkg::OP_LBUF, nice_isa_pkg::OP_SBUF,
                            nice_isa_pkg::OP_ROWSUM};
      @(negedge nice_clk);
      cmd_q.delete();
      cmd_allowed = row_op;
      i_req_valid = 1'b1;
      i_req_inst  = t.inst;
      i_req_rs1   = t.rs1;
      i_req_rs2   = t.rs2;
      i_rsp_ready = (t.stall == 0);
      wait_for(t.name, 1'b0);
      check_flag({t.name, " 1cyc type"}, !row_op, o_1cyc_type);
      if (!row_op) begin
         check_err({t.name, " 1cyc"}, t.op == nice_isa_pkg::OP_ILLEGAL, o_1cyc_err);
         check_word({t.name, " 1cyc rdat"},
                    (t.op == nice_isa_pkg::OP_ADD) ? t.rs1 + t.rs2 : '0, o_1cyc_rdat);
         if (t.op == nice_isa_pkg::OP_CROWBUF) begin
            for (int k = 0; k < `NICE_ROW_LEN; k++) sh_row[k] = '0;
         end
         @(negedge nice_clk);
         i_req_valid = 1'b0;
      end else begin
         @(negedge nice_clk);
         i_req_valid = 1'b0;
         wait_for(t.name, 1'b1);
         held = o_rsp;
         check_flag({t.name, " req ready while responding"}, 1'b0, o_req_ready);
         for (int s = 0; s < t.stall; s++) begin
            if (s == t.stall - 1) begin
               @(negedge nice_clk);
               i_rsp_ready = 1'b1;
            end
            @(posedge nice_clk);
            check_flag({t.name, " held rsp valid"}, 1'b1, o_rsp.valid);
            check_word({t.name, " held rsp rdat"}, held.rdat, o_rsp.rdat);
            check_err({t.name, " held rsp"}, held.err, o_rsp.err);
            check_flag({t.name, " req ready under stall"}, 1'b0, o_req_ready);
         end
         if (cmd_q.size() != `NICE_ROW_LEN) begin
            $display("%s: saw %0d memory commands instead of %0d", t.name, cmd_q.size(),
                     `NICE_ROW_LEN);
            abort_run();
         end
         exp_rdat = '0;
         exp_err  = 1'b0;
         for (int k = 0; k < `NICE_ROW_LEN; k++) begin
            a       = t.rs1 + k * `NICE_ADDR_STEP;
            w       = sh_mem[word_idx(a)];
            exp_err = exp_err || (a == ERR_ADDR);
            check_addr({t.name, " cmd addr"}, a, cmd_q[k].addr);
            check_flag({t.name, " cmd read"}, t.op != nice_isa_pkg::OP_SBUF, cmd_q[k].read);
            case (t.op)
               nice_isa_pkg::OP_LBUF: sh_row[k] = w;
               nice_isa_pkg::OP_SBUF: begin
                  check_word({t.name, " cmd wdata"}, sh_row[k], cmd_q[k].wdata);
                  sh_mem[word_idx(a)] = sh_row[k];
                  check_word({t.name, " stored word"}, sh_row[k], u_mem_model.mem[word_idx(a)]);
               end
               default: begin
                  exp_rdat  = exp_rdat + w;
                  sh_row[k] = sh_row[k] + w;   // rowsum also adds into the row
               end
            endcase
         end
         check_word({t.name, " rsp rdat"}, exp_rdat, held.rdat);
         check_err({t.name, " rsp"}, exp_err, held.err);
         @(negedge nice_clk);
         cmd_allowed = 1'b0;
      end
   endtask

   // any command outside a row operation is a failure
   always @(posedge nice_clk) begin
      if (i_arst_n && o_icb_cmd.valid) begin
         if (!cmd_allowed) begin
            $display("memory command issued while no row operation was active");
            abort_run();
         end
         if (i_icb_cmd_ready) cmd_q.push_back(o_icb_cmd);
      end
   end

   initial begin
      #((N_TESTS * 200 + RST_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before all tests finished");
      abort_run();
   end

   initial begin
      i_arst_n    = 1'b0;
      i_req_valid = 1'b0;
      i_req_inst  = '0;
      i_req_rs1   = '0;
      i_req_rs2   = '0;
      i_rsp_ready = 1'b0;
      cmd_allowed = 1'b0;
      tests = '{
         '{"add wrap",        nice_isa_pkg::OP_ADD,     INST_ADD,     32'hffff_fff0, 32'h25, 0},
         '{"illegal func7",   nice_isa_pkg::OP_ILLEGAL, INST_BAD_F7,  32'h1,         32'h2,  0},
         '{"illegal opcode",  nice_isa_pkg::OP_ILLEGAL, INST_BAD_OPC, 32'h3,         32'h4,  0},
         '{"sbuf after reset", nice_isa_pkg::OP_SBUF,   INST_SBUF,    32'h2c0,       32'h0,  0},
         '{"lbuf A",          nice_isa_pkg::OP_LBUF,    INST_LBUF,    32'h100,       32'h0,  0},
         '{"sbuf B",          nice_isa_pkg::OP_SBUF,    INST_SBUF,    32'h200,       32'h0,  2},
         '{"rowsum C",        nice_isa_pkg::OP_ROWSUM,  INST_ROWSUM,  32'h140,       32'h0,  0},
         '{"sbuf rowsum row", nice_isa_pkg::OP_SBUF,    INST_SBUF,    32'h240,       32'h0,  1},
         '{"crowbuf",         nice_isa_pkg::OP_CROWBUF, INST_CROWBUF, 32'h0,         32'h0,  0},
         '{"sbuf cleared",    nice_isa_pkg::OP_SBUF,    INST_SBUF,    32'h280,       32'h0,  0},
         '{"lbuf err",        nice_isa_pkg::OP_LBUF,    INST_LBUF,    32'h300,       32'h0,  3},
         '{"rowsum err",      nice_isa_pkg::OP_ROWSUM,  INST_ROWSUM,  32'h2fc,       32'h0,  5},
         '{"add",             nice_isa_pkg::OP_ADD,     INST_ADD,     32'h1234_5678, 32'h1111_1111, 0}
      };
      repeat (RST_CYCLES) @(negedge nice_clk);
      i_arst_n = 1'b1;
      @(posedge nice_clk);
      check_flag("reset req ready", 1'b1, o_req_ready);
      check_flag("reset cmd valid", 1'b0, o_icb_cmd.valid);
      check_flag("reset rsp valid", 1'b0, o_rsp.valid);
      check_flag("reset 1cyc type", 1'b0, o_1cyc_type);
      check_err("reset 1cyc", 1'b0, o_1cyc_err);
      for (int i = 0; i < MEM_WORDS; i++) sh_mem[i] = u_mem_model.mem[i];
      for (int k = 0; k < `NICE_ROW_LEN; k++) sh_row[k] = '0;
      for (int t = 0; t < N_TESTS; t++) run_test(tests[t]);
      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+logic
logic/nice_isa_pkg.sv
logic/nice_icb_pkg.sv
logic/nice_req_decode.sv
logic/nice_mem_seq.sv
logic/nice_rowsum_acc.sv
logic/nice_row_buffer.sv
logic/nice_core.sv
verif/nice_mem_model.sv
verif/nice_core_tb.sv
